//--- Makefile
VERILATOR ?= verilator
TOP       ?= mem_subsystem_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
LINTFLAGS ?= --lint-only --timing --timescale 1ns/1ps -Wall
PASS_MSG  ?= Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- logic/bus_router.sv
`default_nettype none

module bus_router (
    input  logic        clk,
    input  logic        reset,

    input  logic [31:0] address,
    input  logic        sel,
    input  logic        read,
    input  logic [3:0]  write_mask,
    input  logic [31:0] write_value,
    output logic [31:0] read_value,
    output logic        ready,

    output logic        ram_sel,
    input  logic [31:0] ram_read_value,
    input  logic        ram_ready,

    output logic        cache_sel,
    input  logic [31:0] cache_read_value,
    input  logic        cache_ready
);
    logic [3:0] region;
    logic       is_write;
    logic       access;
    logic       local_sel;
    logic       local_ready;

    assign region   = address[31:28];
    assign is_write = |write_mask;
    assign access   = sel && (read || is_write);

    assign ram_sel   = access && region == mem_pkg::region_ram;
    assign cache_sel = access && !is_write && region == mem_pkg::region_flash;

    // flash writes and unmapped space are answered here
    assign local_sel = access && !ram_sel && !cache_sel;

    always_ff @(posedge clk) begin
        if (reset) begin
            local_ready <= 1'b0;
        end else begin
            local_ready <= local_sel && !local_ready;
        end
    end

    // unselected targets drive zero and the local answer is zero
    assign read_value = ram_read_value | cache_read_value;
    assign ready      = ram_ready | cache_ready | local_ready;

    // at most one target answers a request
    assert property (@(posedge clk) disable iff (reset)
        $onehot0({ram_ready, cache_ready, local_ready}));

    // request stays put until it is acknowledged
    assert property (@(posedge clk) disable iff (reset)
        sel && !ready |=> sel && $stable(address) && $stable(read)
            && $stable(write_mask) && $stable(write_value));

endmodule

`default_nettype wire

//--- logic/flash.sv
`default_nettype none

module flash (
    input  logic        clk,
    input  logic        reset,

    input  logic        io0_in,
    input  logic        io1_in,
    output logic        spi_clk,
    output logic        spi_csn,
    output logic        io0_en,
    output logic        io1_en,
    output logic        io0_out,
    output logic        io1_out,

    input  logic [31:0] address,
    input  logic        sel,
    input  logic        read,
    input  logic [3:0]  write_mask,
    input  logic [31:0] write_value,
    output logic [31:0] read_value,
    output logic        ready
);
    typedef enum logic [1:0] {
        state_idle,
        state_write_cmd,
        state_read_data,
        state_done
    } state_t;

    state_t      state;
    logic [4:0]  bits;
    logic [30:0] shift_reg;
    logic [31:0] word;
    logic [31:0] read_cmd;

    // single spi only, io1 is always the flash's output
    assign spi_clk = clk;
    assign io0_en  = 1'b1;
    assign io1_en  = 1'b0;
    assign io1_out = 1'b0;

    assign read_cmd   = {mem_pkg::flash_cmd_read, address[23:0]};
    assign read_value = sel ? word : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= state_idle;
            spi_csn <= 1'b1;
            io0_out <= 1'b0;
            bits    <= '0;
            ready   <= 1'b0;
        end else begin
            ready <= 1'b0;
            case (state)
                state_idle: begin
                    // ignore the request still held during the ready cycle
                    if (sel && read && !(|write_mask) && !ready) begin
                        spi_csn   <= 1'b0;
                        io0_out   <= read_cmd[31];
                        shift_reg <= read_cmd[30:0];
                        bits      <= 5'd31;
                        state     <= state_write_cmd;
                    end
                end
                state_write_cmd: begin
                    if (|bits) begin
                        io0_out   <= shift_reg[30];
                        shift_reg <= {shift_reg[29:0], 1'b0};
                        bits      <= bits - 5'd1;
                    end else begin
                        // first data bit arrives after the next falling edge
                        bits  <= 5'd31;
                        state <= state_read_data;
                    end
                end
                state_read_data: begin
                    if (|bits) begin
                        shift_reg <= {shift_reg[29:0], io1_in};
                        bits      <= bits - 5'd1;
                    end else begin
                        spi_csn <= 1'b1;
                        word    <= {shift_reg, io1_in};
                        state   <= state_done;
                    end
                end
                state_done: begin
                    ready <= 1'b1;
                    state <= state_idle;
                end
                default: state <= state_idle;
            endcase
        end
    end

    // chip select follows the command and data phases only
    assert property (@(posedge clk) disable iff (reset)
        !spi_csn |-> (state == state_write_cmd || state == state_read_data));

    // the router and cache keep writes away from the controller
    assert property (@(posedge clk) disable iff (reset)
        sel |-> write_mask == 4'b0);

endmodule

`default_nettype wire

//--- logic/flash_cache.sv
`default_nettype none

module flash_cache #(
    parameter int cache_lines = mem_pkg::default_cache_lines
) (
    input  logic        clk,
    input  logic        reset,

    input  logic [31:0] address,
    input  logic        sel,
    input  logic        read,
    output logic [31:0] read_value,
    output logic        ready,

    output logic [31:0] flash_address,
    output logic        flash_sel,
    output logic        flash_read,
    input  logic [31:0] flash_read_value,
    input  logic        flash_ready
);
    localparam int index_bits = $clog2(cache_lines);
    localparam int tag_bits   = 22 - index_bits; // flash space is 24 bits

    logic [cache_lines-1:0] valid;
    logic [tag_bits-1:0]    tags [cache_lines];
    logic [31:0]            lines [cache_lines];

    logic [index_bits-1:0] index;
    logic [tag_bits-1:0]   tag;
    logic                  lookup_hit;
    logic                  fill;
    logic                  hit_ready;
    logic [31:0]           hit_value;

    assign index      = address[2 +: index_bits];
    assign tag        = address[2 + index_bits +: tag_bits];
    assign lookup_hit = sel && read && valid[index] && tags[index] == tag;

    // a miss goes straight to the controller in the same cycle
    assign flash_address = address;
    assign flash_read    = read;
    assign flash_sel     = sel && read && !lookup_hit;
    assign fill          = flash_sel && flash_ready;

    assign ready      = hit_ready | fill;
    assign read_value = !sel ? '0 : (fill ? flash_read_value : hit_value);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid     <= '0;
            hit_ready <= 1'b0;
        end else begin
            hit_ready <= lookup_hit && !hit_ready; // one pulse per held request
            if (fill) begin
                valid[index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        hit_value <= lines[index];
        if (fill) begin
            tags[index]  <= tag;
            lines[index] <= flash_read_value;
        end
    end

    // a hit is served without touching the spi bus, up to its ready cycle
    assert property (@(posedge clk) disable iff (reset)
        lookup_hit && !hit_ready |=> !flash_sel);

endmodule

`default_nettype wire

//--- logic/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // serial flash read opcode, followed by 24 address bits
    localparam logic [7:0] flash_cmd_read = 8'h03;

    // region codes live in address bits 31 to 28
    localparam logic [3:0] region_flash = 4'd0;
    localparam logic [3:0] region_ram   = 4'd2; // ram starts at 2000_0000

    // sizes in words, powers of two
    localparam int default_ram_words   = 256;
    localparam int default_cache_lines = 16;

endpackage

`default_nettype wire

//--- logic/mem_subsystem.sv
`default_nettype none

module mem_subsystem #(
    parameter int ram_words   = mem_pkg::default_ram_words,
    parameter int cache_lines = mem_pkg::default_cache_lines
) (
    input  logic        clk,
    input  logic        reset,

    input  logic [31:0] address,
    input  logic        sel,
    input  logic        read,
    input  logic [3:0]  write_mask,
    input  logic [31:0] write_value,
    output logic [31:0] read_value,
    output logic        ready,

    input  logic        io0_in,
    input  logic        io1_in,
    output logic        spi_clk,
    output logic        spi_csn,
    output logic        io0_en,
    output logic        io1_en,
    output logic        io0_out,
    output logic        io1_out
);
    logic        ram_sel;
    logic [31:0] ram_read_value;
    logic        ram_ready;

    logic        cache_sel;
    logic [31:0] cache_read_value;
    logic        cache_ready;

    logic [31:0] flash_address;
    logic        flash_sel;
    logic        flash_read;
    logic [31:0] flash_read_value;
    logic        flash_ready;

    bus_router i_bus_router (
        .clk              (clk),
        .reset            (reset),
        .address          (address),
        .sel              (sel),
        .read             (read),
        .write_mask       (write_mask),
        .write_value      (write_value),
        .read_value       (read_value),
        .ready            (ready),
        .ram_sel          (ram_sel),
        .ram_read_value   (ram_read_value),
        .ram_ready        (ram_ready),
        .cache_sel        (cache_sel),
        .cache_read_value (cache_read_value),
        .cache_ready      (cache_ready)
    );

    ram #(
        .ram_words (ram_words)
    ) i_ram (
        .clk         (clk),
        .reset       (reset),
        .address     (address),
        .sel         (ram_sel),
        .read        (read),
        .write_mask  (write_mask),
        .write_value (write_value),
        .read_value  (ram_read_value),
        .ready       (ram_ready)
    );

    flash_cache #(
        .cache_lines (cache_lines)
    ) i_flash_cache (
        .clk              (clk),
        .reset            (reset),
        .address          (address),
        .sel              (cache_sel),
        .read             (read),
        .read_value       (cache_read_value),
        .ready            (cache_ready),
        .flash_address    (flash_address),
        .flash_sel        (flash_sel),
        .flash_read       (flash_read),
        .flash_read_value (flash_read_value),
        .flash_ready      (flash_ready)
    );

    flash i_flash (
        .clk         (clk),
        .reset       (reset),
        .io0_in      (io0_in),
        .io1_in      (io1_in),
        .spi_clk     (spi_clk),
        .spi_csn     (spi_csn),
        .io0_en      (io0_en),
        .io1_en      (io1_en),
        .io0_out     (io0_out),
        .io1_out     (io1_out),
        .address     (flash_address),
        .sel         (flash_sel),
        .read        (flash_read),
        .write_mask  (write_mask),
        .write_value (write_value),
        .read_value  (flash_read_value),
        .ready       (flash_ready)
    );

endmodule

`default_nettype wire

//--- logic/ram.sv
`default_nettype none

module ram #(
    parameter int ram_words = mem_pkg::default_ram_words
) (
    input  logic        clk,
    input  logic        reset,

    input  logic [31:0] address,
    input  logic        sel,
    input  logic        read,
    input  logic [3:0]  write_mask,
    input  logic [31:0] write_value,
    output logic [31:0] read_value,
    output logic        ready
);
    localparam int index_bits = $clog2(ram_words);

    logic [31:0]           mem [ram_words];
    logic [index_bits-1:0] index;
    logic [31:0]           data;
    logic                  start;

    assign index      = address[2 +: index_bits]; // wraps modulo depth
    assign start      = sel && (read || |write_mask) && !ready;
    assign read_value = sel ? data : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            ready <= 1'b0;
        end else begin
            ready <= start;
        end
    end

    always_ff @(posedge clk) begin
        data <= mem[index];
        if (start) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (write_mask[lane]) begin
                    mem[index][lane*8 +: 8] <= write_value[lane*8 +: 8];
                end
            end
        end
    end

    // master never mixes a read with a write
    assert property (@(posedge clk) disable iff (reset)
        sel |-> !(read && |write_mask));

endmodule

`default_nettype wire

//--- sources.f
logic/mem_pkg.sv
logic/flash.sv
logic/flash_cache.sv
logic/ram.sv
logic/bus_router.sv
logic/mem_subsystem.sv
tb/spi_flash_model.sv
tb/mem_subsystem_tb.sv

//--- tb/mem_subsystem_tb.sv
`default_nettype none

module mem_subsystem_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ram_words   = mem_pkg::default_ram_words;
    localparam int cache_lines = mem_pkg::default_cache_lines;
    localparam int cycle_limit = 20000; // about 3x the longest run

    logic        clk = 1'b0;
    logic        reset;
    logic [31:0] address;
    logic        sel;
    logic        read;
    logic [3:0]  write_mask;
    logic [31:0] write_value;
    logic [31:0] read_value;
    logic        ready;
    logic        spi_clk;
    logic        spi_csn;
    logic        io0_in;
    logic        io1_in;
    logic        io0_en;
    logic        io1_en;
    logic        io0_out;
    logic        io1_out;

    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          test_errors = 0;
    int          cycle_count = 0;
    int          csn_low_count = 0;
    int          io_dir_faults = 0;
    logic [31:0] lcg_state = 32'h0acf3616;
    logic [31:0] ram_shadow [ram_words];
    bit          ram_written [ram_words];
    logic [31:0] flash_addrs [4] = '{32'h0000_0000, 32'h0000_0004,
                                     32'h0012_3458, 32'h00ab_cdec};

    assign io0_in = 1'b0; // unused in single spi mode

    mem_subsystem #(
        .ram_words   (ram_words),
        .cache_lines (cache_lines)
    ) i_mem_subsystem (
        .clk (clk), .reset (reset),
        .address (address), .sel (sel), .read (read), .write_mask (write_mask),
        .write_value (write_value), .read_value (read_value), .ready (ready),
        .io0_in (io0_in), .io1_in (io1_in), .spi_clk (spi_clk), .spi_csn (spi_csn),
        .io0_en (io0_en), .io1_en (io1_en), .io0_out (io0_out), .io1_out (io1_out)
    );

    spi_flash_model i_spi_flash_model (
        .spi_clk (spi_clk), .spi_csn (spi_csn), .io0 (io0_out), .io1 (io1_in)
    );

    always #20 clk = ~clk;

    // io directions stay fixed while the flash is selected
    always @(negedge clk) begin
        if (!spi_csn) begin
            csn_low_count++;
            if (io0_en !== 1'b1 || io1_en !== 1'b0 || io1_out !== 1'b0) begin
                io_dir_faults++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("run stopped after %0d cycles, a request never finished", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int ram_slot(input logic [31:0] addr);
        return int'((addr >> 2) % ram_words);
    endfunction

    // bytes a to a+3 as the xor of the address bytes with a5
    function automatic logic [31:0] expected_flash_word(input logic [31:0] addr);
        logic [31:0] word;
        logic [23:0] a;
        word = '0;
        for (int i = 0; i < 4; i++) begin
            a = addr[23:0] + 24'(i);
            word = {word[23:0], a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'ha5};
        end
        return word;
    endfunction

    task automatic compare_word(input string name, input logic [31:0] addr,
                                input logic [31:0] got, input logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("FAILED %s at 0x%08h: got 0x%08h, expected 0x%08h",
                     name, addr, got, expected);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic expected);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
        end
    endtask

    task automatic confirm(input bit condition, input string what);
        checks++;
        assert (condition) else begin
            errors++;
            $display("%s", what);
        end
    endtask

    // count from the request edge to the edge that sees ready
    task automatic wait_ready(output logic [31:0] data, output int cycles);
        @(posedge clk);
        cycles = 1;
        @(negedge clk);
        while (!ready) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end
        data = read_value;
        @(posedge clk);
        #2;
        sel = 1'b0;
        read = 1'b0;
        write_mask = 4'h0;
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data, output int cycles);
        @(posedge clk);
        #2;
        address = addr;
        sel = 1'b1;
        read = 1'b1;
        wait_ready(data, cycles);
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [3:0] mask,
                             input logic [31:0] value, output int cycles);
        logic [31:0] data;
        @(posedge clk);
        #2;
        address = addr;
        sel = 1'b1;
        write_mask = mask;
        write_value = value;
        wait_ready(data, cycles);
    endtask

    task automatic ram_store(input logic [31:0] addr, input logic [3:0] mask,
                             input logic [31:0] value);
        int cycles;
        int slot;
        slot = ram_slot(addr);
        bus_write(addr, mask, value, cycles);
        for (int lane = 0; lane < 4; lane++) begin
            if (mask[lane]) ram_shadow[slot][lane*8 +: 8] = value[lane*8 +: 8];
        end
        ram_written[slot] = 1'b1;
        confirm(cycles == 1,
                $sformatf("ram write to 0x%08h took %0d cycles instead of 1", addr, cycles));
    endtask

    task automatic ram_load(input logic [31:0] addr);
        logic [31:0] data;
        int cycles;
        bus_read(addr, data, cycles);
        compare_word("read_value", addr, data, ram_shadow[ram_slot(addr)]);
        confirm(cycles == 1,
                $sformatf("ram read at 0x%08h took %0d cycles instead of 1", addr, cycles));
    endtask

    task automatic flash_load(input logic [31:0] addr, output int cycles, output int csn_low);
        logic [31:0] data;
        int csn_before;
        csn_before = csn_low_count;
        bus_read(addr, data, cycles);
        csn_low = csn_low_count - csn_before;
        compare_word("read_value", addr, data, expected_flash_word(addr));
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("test %0d %s done, %0d errors", tests, name, errors - test_errors);
        test_errors = errors;
    endtask

    task automatic ram_byte_masks();
        logic [31:0] base;
        base = 32'h2000_0000;
        ram_store(base + 32'h000, 4'hf, 32'h0123_4567);
        ram_store(base + 32'h004, 4'hf, 32'h89ab_cdef);
        ram_store(base + 32'h010, 4'hf, 32'h5a5a_a5a5);
        ram_store(base + 32'h3fc, 4'hf, 32'hcafe_f00d);
        ram_store(base + 32'h000, 4'b0101, 32'haabb_ccdd);
        ram_store(base + 32'h004, 4'b1000, 32'h7700_0000);
        ram_store(base + 32'h010, 4'b0010, 32'h0000_3300);
        ram_store(base + 32'h3fc, 4'b0110, 32'h00ee_ff00);
        ram_store(base + 32'h400, 4'b1000, 32'h9900_0000); // wraps onto word 0
        ram_load(base + 32'h000);
        ram_load(base + 32'h004);
        ram_load(base + 32'h010);
        ram_load(base + 32'h3fc);
        report_test("ram byte masks");
    endtask

    task automatic flash_miss_reads();
        int cycles;
        int csn_low;
        foreach (flash_addrs[i]) begin
            flash_load(flash_addrs[i], cycles, csn_low);
            confirm(csn_low > 0,
                    $sformatf("no spi transfer for the miss at 0x%08h", flash_addrs[i]));
            compare_bit("spi_csn", spi_csn, 1'b1);
        end
        confirm(io_dir_faults == 0, "io0_en, io1_en or io1_out left single spi mode");
        report_test("flash miss");
    endtask

    task automatic cache_hit_reads();
        int cycles;
        int csn_low;
        foreach (flash_addrs[i]) begin
            flash_load(flash_addrs[i], cycles, csn_low);
            confirm(cycles == 1 && csn_low == 0,
                    $sformatf("hit at 0x%08h took %0d cycles with %0d spi cycles",
                              flash_addrs[i], cycles, csn_low));
        end
        report_test("cache hit");
    endtask

    task automatic conflict_eviction();
        logic [31:0] first;
        logic [31:0] second;
        int cycles;
        int csn_low;
        first = 32'h0000_0240;
        second = first + 32'(cache_lines * 4); // same line with another tag
        for (int i = 0; i < 8; i++) begin
            flash_load(i[0] ? second : first, cycles, csn_low);
            confirm(csn_low > 0, $sformatf("read %0d of the conflict pair hit the cache", i));
        end
        report_test("conflict eviction");
    endtask

    task automatic flash_write_and_unmapped();
        logic [31:0] data;
        int cycles;
        int csn_low;
        int csn_before;
        csn_before = csn_low_count;
        bus_write(32'h0000_0100, 4'hf, 32'hdead_beef, cycles);
        confirm(cycles == 1 && csn_low_count == csn_before,
                "flash write not answered in one cycle without spi traffic");
        flash_load(32'h0000_0100, cycles, csn_low);
        bus_read(32'h5000_0010, data, cycles);
        compare_word("read_value", 32'h5000_0010, data, 32'h0);
        confirm(cycles == 1, "unmapped read took more than one cycle");
        bus_write(32'h5000_0010, 4'hf, 32'h1234_5678, cycles);
        confirm(cycles == 1, "unmapped write took more than one cycle");
        bus_read(32'h5000_0010, data, cycles);
        compare_word("read_value", 32'h5000_0010, data, 32'h0);
        report_test("flash write and unmapped");
    endtask

    task automatic random_mix();
        logic [31:0] r;
        logic [31:0] addr;
        logic [3:0]  mask;
        int cycles;
        int csn_low;
        for (int n = 0; n < 200; n++) begin
            r = next_random();
            if (r[31]) begin
                addr = {20'h20000, r[21:12], 2'b00}; // beyond ram_words so it aliases
                if (r[30] && ram_written[ram_slot(addr)]) begin
                    ram_load(addr);
                end else begin
                    mask = ram_written[ram_slot(addr)] ? r[27:24] : 4'hf;
                    if (mask == 4'h0) mask = 4'hf;
                    ram_store(addr, mask, next_random());
                end
            end else begin
                flash_load({24'h0, r[29:24], 2'b00}, cycles, csn_low);
            end
        end
        report_test("random mix");
    endtask

    initial begin
        reset = 1'b1;
        address = '0;
        sel = 1'b0;
        read = 1'b0;
        write_mask = 4'h0;
        write_value = '0;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        compare_bit("spi_csn", spi_csn, 1'b1);
        compare_bit("ready", ready, 1'b0);
        compare_bit("io0_en", io0_en, 1'b1);
        compare_bit("io1_en", io1_en, 1'b0);
        compare_bit("io1_out", io1_out, 1'b0);
        ram_byte_masks();
        flash_miss_reads();
        cache_hit_reads();
        conflict_eviction();
        flash_write_and_unmapped();
        random_mix();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/spi_flash_model.sv
`default_nettype none

// serial flash that only knows the read command, content comes from the byte address
module spi_flash_model (
    input  logic spi_clk,
    input  logic spi_csn,
    input  logic io0,
    output logic io1
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [6:0]  bit_count = '0;
    logic [31:0] command   = '0;
    logic [31:0] data_word = '0;
    logic [31:0] next_word;
    logic        out_bit   = 1'b0;

    function automatic logic [7:0] content_byte(input logic [23:0] a);
        return a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'ha5;
    endfunction

    // first byte of the word is the most significant
    assign next_word = {content_byte(command[23:0]), content_byte(command[23:0] + 24'd1),
                        content_byte(command[23:0] + 24'd2), content_byte(command[23:0] + 24'd3)};
    assign io1 = out_bit;

    always @(posedge spi_clk) begin
        if (spi_csn) begin
            bit_count <= '0;
        end else if (bit_count < 7'd64) begin
            bit_count <= bit_count + 7'd1;
            if (bit_count < 7'd32) begin
                command <= {command[30:0], io0}; // opcode then address, msb first
            end
        end
    end

    // data bits change after the falling edge
    always @(negedge spi_clk) begin
        if (spi_csn || bit_count < 7'd32 || bit_count > 7'd63 || command[31:24] != 8'h03) begin
            out_bit <= 1'b0;
        end else if (bit_count == 7'd32) begin
            data_word <= next_word;
            out_bit   <= next_word[31];
        end else begin
            out_bit <= data_word[5'd31 - bit_count[4:0]];
        end
    end

endmodule

`default_nettype wire
